//--- dv/neural_chip_properties.sv
`timescale 1ns/1ps
`default_nettype none

module neural_chip_properties (
    input logic clk,
    input logic RESET,
    input logic req,
    input logic ack
);

    int unsigned fail_count = 0;  // Read by the testbench at the end of the run

    // ack is held low throughout reset
    ack_low_in_reset: assert property (@(posedge clk) !RESET |-> !ack)
        else begin
            $error("ack high while RESET is low");
            fail_count++;
        end

    // No ack without an open request
    ack_needs_req: assert property (@(posedge clk) disable iff (!RESET) $rose(ack) |-> req)
        else begin
            $error("ack rose with req low");
            fail_count++;
        end

    // Handshake closes one cycle after req drops
    ack_follows_req: assert property (@(posedge clk) disable iff (!RESET)
        ack && $fell(req) |=> !ack)
        else begin
            $error("ack still high one cycle after req fell");
            fail_count++;
        end

endmodule

bind matmul_controller neural_chip_properties u_props (
    .clk   (clk),
    .RESET (RESET),
    .req   (req),
    .ack   (ack)
);

`default_nettype wire

//--- dv/neural_chip_tb.sv
`timescale 1ns/1ps
`default_nettype none

module neural_chip_tb;

    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DLY      = 5;
    localparam int ACK_CYCLES     = 8;             // From the edge that sees req to ack high
    localparam int NUM_VECS       = 6;
    localparam int RUNS           = NUM_VECS + 2;  // Table plus aborted and recovery requests
    localparam int TIMEOUT_CYCLES = RUNS * 20 + 20;

    typedef struct packed {
        systolic_pkg::operands_t ops;
        systolic_pkg::matrix_t   expected;
    } vector_t;

    logic                    clk;
    logic                    RESET;
    logic                    req;
    systolic_pkg::operands_t operands;
    logic                    ack;
    systolic_pkg::matrix_t   result;

    vector_t     vectors [NUM_VECS];
    logic [31:0] lcg_state = 32'hb120;
    int          errors    = 0;

    neural_chip DUT (
        .clk      (clk),
        .RESET    (RESET),
        .req      (req),
        .operands (operands),
        .ack      (ack),
        .result   (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Row by row, values as raw bf16 codes
    function automatic systolic_pkg::matrix_t make_matrix(input logic [15:0] m00, m01, m10, m11);
        systolic_pkg::matrix_t m;
        m[0][0] = m00;
        m[0][1] = m01;
        m[1][0] = m10;
        m[1][1] = m11;
        return m;
    endfunction

    function automatic int unsigned next_gap();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[17:16];  // 0 to 3 cycles
    endfunction

    // Every action happens a little after the rising edge
    task automatic step();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic load_vectors();
        // Identity A passes B through
        vectors[0].ops.a    = make_matrix(16'h3F80, 16'h0000, 16'h0000, 16'h3F80);
        vectors[0].ops.b    = make_matrix(16'h4000, 16'h4040, 16'hC080, 16'h3F00);
        vectors[0].expected = make_matrix(16'h4000, 16'h4040, 16'hC080, 16'h3F00);
        // [1 2; 3 4] x [2 1; 1 3] = [4 7; 10 15]
        vectors[1].ops.a    = make_matrix(16'h3F80, 16'h4000, 16'h4040, 16'h4080);
        vectors[1].ops.b    = make_matrix(16'h4000, 16'h3F80, 16'h3F80, 16'h4040);
        vectors[1].expected = make_matrix(16'h4080, 16'h40E0, 16'h4120, 16'h4170);
        // Every sum carries into the exponent, [32 20; 20 12]
        vectors[2].ops.a    = make_matrix(16'h4080, 16'h4080, 16'h4040, 16'h4000);
        vectors[2].ops.b    = make_matrix(16'h4080, 16'h4000, 16'h4080, 16'h4040);
        vectors[2].expected = make_matrix(16'h4200, 16'h41A0, 16'h41A0, 16'h4140);
        // Zero A
        vectors[3].ops.a    = make_matrix(16'h0000, 16'h0000, 16'h0000, 16'h0000);
        vectors[3].ops.b    = make_matrix(16'h4000, 16'h4040, 16'h4080, 16'h40A0);
        vectors[3].expected = make_matrix(16'h0000, 16'h0000, 16'h0000, 16'h0000);
        // Negative products, zero partner, [-6 -2; 12 -3]
        vectors[4].ops.a    = make_matrix(16'hC000, 16'h0000, 16'h0000, 16'h4040);
        vectors[4].ops.b    = make_matrix(16'h4040, 16'h3F80, 16'h4080, 16'hBF80);
        vectors[4].expected = make_matrix(16'hC0C0, 16'hC000, 16'h4140, 16'hC040);
        // 6-2 gives 4, 1-8 gives -8 (larger term's scale, zero mantissa)
        vectors[5].ops.a    = make_matrix(16'h4000, 16'h3F80, 16'h3F80, 16'hC080);
        vectors[5].ops.b    = make_matrix(16'h4040, 16'h3F80, 16'hC000, 16'h4000);
        vectors[5].expected = make_matrix(16'h4080, 16'h4080, 16'h4130, 16'hC100);
    endtask

    task automatic check_result(input systolic_pkg::matrix_t expected);
        for (int i = 0; i < systolic_pkg::GRID_N; i++) begin
            for (int j = 0; j < systolic_pkg::GRID_N; j++) begin
                assert (result[i][j] === expected[i][j]) else begin
                    $display("Error: %0d ns result[%0d][%0d] expected %h got %h",
                             $time, i, j, expected[i][j], result[i][j]);
                    errors++;
                end
            end
        end
    endtask

    // One four-phase transfer
    task automatic run_request(input vector_t vec);
        int cycles;
        int hold;
        repeat (next_gap()) step();
        operands = vec.ops;
        req      = 1'b1;
        step();                                   // Edge that sees req in IDLE
        cycles = 0;
        while (!ack && cycles <= ACK_CYCLES + 4) begin
            step();
            cycles++;
        end
        if (!ack) begin
            $display("No ack came within %0d cycles of the request", cycles);
            errors++;
        end else begin
            assert (cycles == ACK_CYCLES) else begin
                $display("Error: %0d ns ack latency expected %0d got %0d",
                         $time, ACK_CYCLES, cycles);
                errors++;
            end
        end
        check_result(vec.expected);
        hold = next_gap() + 1;
        repeat (hold) begin                       // req held, result must not move
            step();
            check_result(vec.expected);
            assert (ack === 1'b1) else begin
                $display("Error: %0d ns ack expected 1 got %b", $time, ack);
                errors++;
            end
        end
        req = 1'b0;
        step();
        assert (ack === 1'b0) else begin
            $display("Error: %0d ns ack expected 0 got %b", $time, ack);
            errors++;
        end
    endtask

    task automatic reset_during_compute(input vector_t vec);
        operands = vec.ops;
        req      = 1'b1;
        repeat (4) step();                        // LOAD, then into COMPUTE
        assert (DUT.u_ctrl.state_q == systolic_pkg::COMPUTE) else begin
            $display("The controller never reached COMPUTE before the reset");
            errors++;
        end
        RESET = 1'b0;
        req   = 1'b0;
        repeat (ACK_CYCLES) begin                 // A missed reset would let ack pulse in here
            step();
            assert (ack === 1'b0) else begin
                $display("Error: %0d ns ack expected 0 got %b", $time, ack);
                errors++;
            end
        end
        assert (DUT.u_ctrl.state_q == systolic_pkg::IDLE) else begin
            $display("Error: %0d ns state_q expected %0d got %0d",
                     $time, systolic_pkg::IDLE, DUT.u_ctrl.state_q);
            errors++;
        end
        RESET = 1'b1;
        step();
    endtask

    initial begin
        RESET    = 1'b1;
        req      = 1'b0;
        operands = '0;
        load_vectors();
        #1 RESET = 1'b0;                          // Falling edge starts the async reset
        repeat (8) @(posedge clk);
        #DRIVE_DLY RESET = 1'b1;
        for (int n = 0; n < NUM_VECS; n++) begin
            run_request(vectors[n]);
        end
        reset_during_compute(vectors[1]);
        run_request(vectors[1]);                  // Engine must recover cleanly
        errors += DUT.u_ctrl.u_props.fail_count;
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("The run did not finish within %0d clock periods", TIMEOUT_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- neural_chip.f
source/systolic_pkg.sv
source/bf16_mul.sv
source/bf16_add.sv
source/processing_element.sv
source/systolic_array.sv
source/matmul_controller.sv
source/neural_chip.sv
dv/neural_chip_properties.sv
dv/neural_chip_tb.sv

//--- source/bf16_add.sv
`timescale 1ns/1ps
`default_nettype none

module bf16_add (
    input  systolic_pkg::bf16_t a,
    input  systolic_pkg::bf16_t b,
    output systolic_pkg::bf16_t sum
);

    systolic_pkg::bf16_t            hi_op;        // Larger magnitude
    systolic_pkg::bf16_t            lo_op;
    logic [systolic_pkg::M_W:0]     sig_hi;
    logic [systolic_pkg::M_W:0]     sig_lo;
    logic [systolic_pkg::M_W:0]     sig_lo_al;    // Aligned to hi_op's exponent
    logic [systolic_pkg::EXP_W-1:0] exp_diff;
    logic [systolic_pkg::M_W+1:0]   sig_sum;      // MSB is the carry
    logic                           exc;
    logic                           opp_sign;
    logic                           lo_zero;

    // Order by magnitude, sign bit ignored
    assign {hi_op, lo_op} = (a[systolic_pkg::DATA_W-2:0] < b[systolic_pkg::DATA_W-2:0])
                          ? {b, a} : {a, b};

    // Zero exponent means zero, no hidden bit
    assign sig_hi = (hi_op.exponent == '0) ? '0 : {1'b1, hi_op.mantissa};
    assign sig_lo = (lo_op.exponent == '0) ? '0 : {1'b1, lo_op.mantissa};

    assign exp_diff  = hi_op.exponent - lo_op.exponent;
    assign sig_lo_al = sig_lo >> exp_diff;
    assign sig_sum   = {1'b0, sig_hi} + {1'b0, sig_lo_al};

    assign exc      = (&a.exponent) | (&b.exponent);  // inf or NaN on either side
    assign opp_sign = hi_op.sign ^ lo_op.sign;
    assign lo_zero  = lo_op.exponent == '0;

    always_comb begin
        sum.sign = hi_op.sign;
        if (exc) begin
            sum = '0;
        end else if (opp_sign && !lo_zero) begin
            // No subtractor, keep the larger term's scale only
            sum.exponent = hi_op.exponent;
            sum.mantissa = '0;
        end else if (sig_sum[systolic_pkg::M_W+1]) begin
            sum.exponent = hi_op.exponent + 1'b1;  // Carry renormalises
            sum.mantissa = sig_sum[systolic_pkg::M_W:1];
        end else begin
            sum.exponent = hi_op.exponent;
            sum.mantissa = sig_sum[systolic_pkg::M_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- source/bf16_mul.sv
`timescale 1ns/1ps
`default_nettype none

module bf16_mul (
    input  systolic_pkg::bf16_t a,
    input  systolic_pkg::bf16_t b,
    output systolic_pkg::bf16_t product
);

    logic [systolic_pkg::MULT_W-1:0] sig_prod;    // 1.m x 1.m, range [1,4)
    logic                            norm_hi;     // Product is 2.0 or above
    logic [systolic_pkg::M_W-1:0]    man_norm;
    logic [systolic_pkg::EXP_W+1:0]  exp_sum;     // Two guard bits for the raw sum
    logic [systolic_pkg::EXP_W+1:0]  exp_biased;
    logic                            is_zero;
    logic                            ovf;
    logic                            unf;

    // Hidden bits restored before the multiply
    assign sig_prod = {1'b1, a.mantissa} * {1'b1, b.mantissa};
    assign norm_hi  = sig_prod[systolic_pkg::MULT_W-1];

    // Drop one or two leading bits, the rest is truncated
    assign man_norm = norm_hi ? sig_prod[systolic_pkg::MULT_W-2 -: systolic_pkg::M_W]
                              : sig_prod[systolic_pkg::MULT_W-3 -: systolic_pkg::M_W];

    // Raw exponent sum still carries two biases
    assign exp_sum = {2'b00, a.exponent} + {2'b00, b.exponent}
                   + (systolic_pkg::EXP_W+2)'(norm_hi);
    assign exp_biased = exp_sum - (systolic_pkg::EXP_W+2)'(systolic_pkg::EXP_BIAS);

    assign is_zero = (a.exponent == '0) || (b.exponent == '0);
    assign unf     = exp_sum <= systolic_pkg::EXP_BIAS;  // Biased result of 0 or below
    assign ovf     = exp_sum > (systolic_pkg::EXP_MAX + systolic_pkg::EXP_BIAS);

    always_comb begin
        product.sign = a.sign ^ b.sign;
        if (is_zero) begin
            product = '0;                          // Clean +0, no sign
        end else if (unf) begin
            product.exponent = '0;                 // Flush to signed zero
            product.mantissa = '0;
        end else if (ovf) begin
            product.exponent = '1;                 // Saturate to infinity
            product.mantissa = '0;
        end else begin
            product.exponent = exp_biased[systolic_pkg::EXP_W-1:0];
            product.mantissa = man_norm;
        end
    end

endmodule

`default_nettype wire

//--- source/matmul_controller.sv
`timescale 1ns/1ps
`default_nettype none

module matmul_controller (
    input  logic clk,
    input  logic RESET,
    input  logic req,
    input  logic done,
    output logic load,
    output logic compute,
    output logic ack
);

    systolic_pkg::ctrl_state_t state_q;
    systolic_pkg::ctrl_state_t state_d;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            systolic_pkg::IDLE: begin
                if (req) state_d = systolic_pkg::LOAD;
            end
            systolic_pkg::LOAD: begin
                state_d = systolic_pkg::COMPUTE;      // Single load cycle
            end
            systolic_pkg::COMPUTE: begin
                if (done) state_d = systolic_pkg::RESPOND;
            end
            systolic_pkg::RESPOND: begin
                if (!req) state_d = systolic_pkg::IDLE;  // Host closed the handshake
            end
            default: begin
                state_d = systolic_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge RESET) begin
        if (!RESET) begin
            state_q <= systolic_pkg::IDLE;
            ack     <= 1'b0;
        end else begin
            state_q <= state_d;
            ack     <= (state_d == systolic_pkg::RESPOND);  // Registered, tracks RESPOND
        end
    end

    // Array strobes decoded from state
    assign load    = (state_q == systolic_pkg::LOAD);
    assign compute = (state_q == systolic_pkg::COMPUTE);

endmodule

`default_nettype wire

//--- source/neural_chip.sv
`timescale 1ns/1ps
`default_nettype none

module neural_chip (
    input  logic                    clk,
    input  logic                    RESET,
    input  logic                    req,
    input  systolic_pkg::operands_t operands,
    output logic                    ack,
    output systolic_pkg::matrix_t   result
);

    logic load;
    logic compute;
    logic done;

    // Four-phase req/ack sequencing
    matmul_controller u_ctrl (
        .clk     (clk),
        .RESET   (RESET),
        .req     (req),
        .done    (done),
        .load    (load),
        .compute (compute),
        .ack     (ack)
    );

    // Operands go straight in, captured on load
    systolic_array u_array (
        .clk      (clk),
        .RESET    (RESET),
        .load     (load),
        .compute  (compute),
        .operands (operands),
        .done     (done),
        .result   (result)
    );

endmodule

`default_nettype wire

//--- source/processing_element.sv
`timescale 1ns/1ps
`default_nettype none

module processing_element (
    input  logic                clk,
    input  logic                RESET,
    input  logic                weight_en,
    input  logic                compute,
    input  systolic_pkg::bf16_t weight_in,
    input  systolic_pkg::bf16_t act_west,
    input  systolic_pkg::bf16_t psum_north,
    output systolic_pkg::bf16_t act_east,
    output systolic_pkg::bf16_t psum_south
);

    systolic_pkg::bf16_t weight_q;  // Stationary for a whole operation
    systolic_pkg::bf16_t prod;
    systolic_pkg::bf16_t acc;

    bf16_mul u_mul (.a(act_west),   .b(weight_q), .product(prod));
    bf16_add u_add (.a(psum_north), .b(prod),     .sum(acc));

    always_ff @(posedge clk) begin
        if (weight_en) weight_q <= weight_in;
    end

    // Activation goes east, accumulated sum goes south
    always_ff @(posedge clk or negedge RESET) begin
        if (!RESET) begin
            act_east   <= '0;
            psum_south <= '0;
        end else if (compute) begin
            act_east   <= act_west;
            psum_south <= acc;
        end
    end

endmodule

`default_nettype wire

//--- source/systolic_array.sv
`timescale 1ns/1ps
`default_nettype none

module systolic_array (
    input  logic                    clk,
    input  logic                    RESET,
    input  logic                    load,
    input  logic                    compute,
    input  systolic_pkg::operands_t operands,
    output logic                    done,
    output systolic_pkg::matrix_t   result
);

    // West feed, one row per k index of the dot product
    systolic_pkg::bf16_t skew_q [systolic_pkg::GRID_N][systolic_pkg::SKEW_LEN];
    // Bottom-row sums, newest at index 0
    systolic_pkg::bf16_t deskew_q [systolic_pkg::DESKEW_LEN][systolic_pkg::GRID_N];

    systolic_pkg::bf16_t act_w  [systolic_pkg::GRID_N][systolic_pkg::GRID_N+1];
    systolic_pkg::bf16_t psum_w [systolic_pkg::GRID_N+1][systolic_pkg::GRID_N];

    logic [$clog2(systolic_pkg::RESULT_CYCLE+1)-1:0] cnt_q;  // Compute cycles since load
    logic capture;

    assign capture = compute && (cnt_q == systolic_pkg::RESULT_CYCLE);

    // Skew and deskew shift registers, result capture
    always_ff @(posedge clk) begin
        if (load) begin
            for (int k = 0; k < systolic_pkg::GRID_N; k++) begin
                for (int p = 0; p < systolic_pkg::SKEW_LEN; p++) begin
                    skew_q[k][p] <= '0;
                end
                // Column k of A, delayed by k slots
                for (int i = 0; i < systolic_pkg::GRID_N; i++) begin
                    skew_q[k][k+i] <= operands.a[i][k];
                end
            end
        end else if (compute) begin
            for (int k = 0; k < systolic_pkg::GRID_N; k++) begin
                for (int p = 0; p < systolic_pkg::SKEW_LEN - 1; p++) begin
                    skew_q[k][p] <= skew_q[k][p+1];  // March toward the grid
                end
                skew_q[k][systolic_pkg::SKEW_LEN-1] <= '0;
            end
            for (int c = 0; c < systolic_pkg::GRID_N; c++) begin
                deskew_q[0][c] <= psum_w[systolic_pkg::GRID_N][c];
                for (int d = 1; d < systolic_pkg::DESKEW_LEN; d++) begin
                    deskew_q[d][c] <= deskew_q[d-1][c];
                end
            end
            if (capture) begin
                // C[i][j] left the grid i+j cycles after C[0][0]
                for (int i = 0; i < systolic_pkg::GRID_N; i++) begin
                    for (int j = 0; j < systolic_pkg::GRID_N; j++) begin
                        result[i][j] <= deskew_q[systolic_pkg::DESKEW_LEN-1-i-j][j];
                    end
                end
            end
        end
    end

    // Cycle counter and done flag
    always_ff @(posedge clk or negedge RESET) begin
        if (!RESET) begin
            cnt_q <= '0;
            done  <= 1'b0;
        end else if (load) begin
            cnt_q <= '0;
            done  <= 1'b0;
        end else if (capture) begin
            cnt_q <= '0;
            done  <= 1'b1;                   // Held until the next load
        end else if (compute && !done) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    for (genvar r = 0; r < systolic_pkg::GRID_N; r++) begin : g_row
        assign act_w[r][0] = skew_q[r][0];
        for (genvar c = 0; c < systolic_pkg::GRID_N; c++) begin : g_col
            if (r == 0) begin : g_top
                assign psum_w[0][c] = '0;    // Nothing above the top row
            end
            // Grid column c holds column c of B
            processing_element u_pe (
                .clk        (clk),
                .RESET      (RESET),
                .weight_en  (load),
                .compute    (compute),
                .weight_in  (operands.b[r][c]),
                .act_west   (act_w[r][c]),
                .psum_north (psum_w[r][c]),
                .act_east   (act_w[r][c+1]),
                .psum_south (psum_w[r+1][c])
            );
        end
    end

endmodule

`default_nettype wire

//--- source/systolic_pkg.sv
`default_nettype none

package systolic_pkg;

    // Brain-float element layout
    localparam int DATA_W   = 16;
    localparam int EXP_W    = 8;
    localparam int M_W      = 7;
    localparam int MULT_W   = 2 * (M_W + 1);  // Hidden bit on both significands
    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX  = 254;            // All ones is reserved for inf/NaN

    // Grid geometry, fixed at 2x2
    localparam int GRID_N       = 2;
    localparam int SKEW_LEN     = GRID_N + GRID_N - 1;
    localparam int DESKEW_LEN   = 2 * GRID_N - 1;
    localparam int RESULT_CYCLE = 2 * GRID_N + 1;  // Compute count when the taps hold C

    typedef struct packed {
        logic             sign;
        logic [EXP_W-1:0] exponent;
        logic [M_W-1:0]   mantissa;
    } bf16_t;

    // Indexed [row][col]
    typedef bf16_t [GRID_N-1:0][GRID_N-1:0] matrix_t;

    // Request payload, C = a * b
    typedef struct packed {
        matrix_t a;
        matrix_t b;
    } operands_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        COMPUTE,
        RESPOND
    } ctrl_state_t;

endpackage

`default_nettype wire
